// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     := ex_stage_tb
RTL_TOP    := ex_stage
FILE_LIST  := ex_stage.f
BUILD_DIR  := obj_dir
PASS_TEXT  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILE_LIST)) $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/alu_datapath.sv
// Addressing-mode shifter and flag-setting ALU of the execute stage, purely combinational
`timescale 1ns/1ns

module alu_datapath (
  input  ex_types_pkg::word_t                rm_value,
  input  ex_types_pkg::word_t                rn_value,
  input  logic [arm_isa_pkg::IMM_WIDTH-1:0]  imm12,
  input  arm_isa_pkg::addr_mode_t            addr_mode,
  input  arm_isa_pkg::alu_op_t               alu_op,
  input  logic                               carry_in,
  output ex_types_pkg::word_t                alu_result,
  output ex_types_pkg::flags_t               alu_flags
);

  import arm_isa_pkg::*;
  import ex_types_pkg::*;

  word_t                 operand_b;
  word_t                 imm8_ext;
  logic [4:0]            rot_amount;
  logic [4:0]            shift_amount;
  logic [WORD_WIDTH:0]   wide;
  logic [WORD_WIDTH:0]   carry_ext;
  word_t                 result;
  logic                  carry_out;
  logic                  overflow;

  function automatic word_t ror_word(input word_t value, input logic [4:0] amount);
    logic [2*WORD_WIDTH-1:0] doubled;
    doubled = {value, value} >> amount;
    return doubled[WORD_WIDTH-1:0];
  endfunction

  // Signed overflow of x + y giving r
  function automatic logic add_ovf(input word_t x, input word_t y, input word_t r);
    return (x[WORD_WIDTH-1] == y[WORD_WIDTH-1]) && (r[WORD_WIDTH-1] != x[WORD_WIDTH-1]);
  endfunction

  // Signed overflow of x - y giving r
  function automatic logic sub_ovf(input word_t x, input word_t y, input word_t r);
    return (x[WORD_WIDTH-1] != y[WORD_WIDTH-1]) && (r[WORD_WIDTH-1] != x[WORD_WIDTH-1]);
  endfunction

  assign imm8_ext     = {{(WORD_WIDTH-8){1'b0}}, imm12[7:0]};
  assign rot_amount   = {imm12[11:8], 1'b0};  // Twice the rotate field
  assign shift_amount = imm12[11:7];
  assign carry_ext    = {{WORD_WIDTH{1'b0}}, carry_in};

  // Second operand
  always_comb begin
    operand_b = '0;
    case (addr_mode)
      AM_ROT_IMM: operand_b = ror_word(imm8_ext, rot_amount);
      AM_REG:     operand_b = rm_value;
      AM_IMM12:   operand_b = {{(WORD_WIDTH-IMM_WIDTH){1'b0}}, imm12};
      AM_SHIFT_REG: begin
        case (shift_t'(imm12[6:5]))
          SH_LSL: operand_b = rm_value << shift_amount;
          SH_LSR: operand_b = rm_value >> shift_amount;
          SH_ASR: operand_b = word_t'($signed(rm_value) >>> shift_amount);
          SH_ROR: operand_b = ror_word(rm_value, shift_amount);
          default: operand_b = rm_value;
        endcase
      end
      default: operand_b = rm_value;
    endcase
  end

  // Arithmetic ops go through the 33-bit wide path for carry
  always_comb begin
    wide      = '0;
    result    = '0;
    carry_out = 1'b0;
    overflow  = 1'b0;
    case (alu_op)
      ALU_AND:  result = rn_value & operand_b;
      ALU_EOR:  result = rn_value ^ operand_b;
      ALU_ORR:  result = rn_value | operand_b;
      ALU_BIC:  result = rn_value & ~operand_b;
      ALU_MOVA: result = rn_value;
      ALU_MOV:  result = operand_b;
      ALU_MVN:  result = ~operand_b;
      ALU_ADD, ALU_ADC: begin
        wide = {1'b0, rn_value} + {1'b0, operand_b};
        if (alu_op == ALU_ADC) begin
          wide = wide + carry_ext;
        end
        result    = wide[WORD_WIDTH-1:0];
        carry_out = wide[WORD_WIDTH];
        overflow  = add_ovf(rn_value, operand_b, result);
      end
      ALU_SUB, ALU_SBC: begin
        wide = {1'b0, rn_value} - {1'b0, operand_b};
        if (alu_op == ALU_SBC) begin
          wide = wide - carry_ext;
        end
        result    = wide[WORD_WIDTH-1:0];
        carry_out = wide[WORD_WIDTH];  // Borrow
        overflow  = sub_ovf(rn_value, operand_b, result);
      end
      ALU_RSB, ALU_RSC: begin
        wide = {1'b0, operand_b} - {1'b0, rn_value};
        if (alu_op == ALU_RSC) begin
          wide = wide - carry_ext;
        end
        result    = wide[WORD_WIDTH-1:0];
        carry_out = wide[WORD_WIDTH];
        overflow  = sub_ovf(operand_b, rn_value, result);
      end
      default: result = '0;  // Unused codes
    endcase
  end

  assign alu_result  = result;
  assign alu_flags.n = result[WORD_WIDTH-1];
  assign alu_flags.z = (result == '0);
  assign alu_flags.c = carry_out;
  assign alu_flags.v = overflow;

endmodule

// File: design/arm_isa_pkg.sv
// Instruction field encodings for the execute stage, imported by the RTL and the testbench
package arm_isa_pkg;

  localparam int IMM_WIDTH = 12;  // Shifter immediate field

  // ALU operation, codes 1000, 1101 and 1111 give zero
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_EOR  = 4'b0001,
    ALU_SUB  = 4'b0010,
    ALU_RSB  = 4'b0011,
    ALU_ADD  = 4'b0100,
    ALU_ADC  = 4'b0101,
    ALU_SBC  = 4'b0110,
    ALU_RSC  = 4'b0111,
    ALU_MOVA = 4'b1001,  // Pass A
    ALU_MOV  = 4'b1010,  // Pass B
    ALU_MVN  = 4'b1011,
    ALU_ORR  = 4'b1100,
    ALU_BIC  = 4'b1110
  } alu_op_t;

  typedef enum logic [1:0] {
    AM_ROT_IMM   = 2'b00,  // imm8 rotated right by 2 * imm12[11:8]
    AM_REG       = 2'b01,  // Rm as is
    AM_IMM12     = 2'b10,  // imm12 zero-extended
    AM_SHIFT_REG = 2'b11   // Rm shifted by imm12[11:7]
  } addr_mode_t;

  typedef enum logic [1:0] {
    SH_LSL = 2'b00,
    SH_LSR = 2'b01,
    SH_ASR = 2'b10,
    SH_ROR = 2'b11
  } shift_t;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE,
    COND_AL,  // Always
    COND_NV   // Never
  } cond_t;

endpackage

// File: design/branch_resolver.sv
// Condition check against the stored flags and branch target adder of the execute stage
`timescale 1ns/1ns

module branch_resolver #(
  parameter int OFFSET_WIDTH = 24
) (
  input  arm_isa_pkg::cond_t         cond,
  input  logic                       is_branch,
  input  logic                       is_link,
  input  logic [OFFSET_WIDTH-1:0]    branch_offset,
  input  ex_types_pkg::word_t        next_pc,
  input  ex_types_pkg::flags_t       flags,
  output logic                       taken,
  output logic                       link_taken,
  output ex_types_pkg::word_t        target
);

  import arm_isa_pkg::*;
  import ex_types_pkg::*;

  logic  cond_holds;
  word_t offset_ext;

  // One table serves both B and BL
  always_comb begin
    cond_holds = 1'b0;
    case (cond)
      COND_EQ: cond_holds = flags.z;
      COND_NE: cond_holds = !flags.z;
      COND_CS: cond_holds = flags.c;
      COND_CC: cond_holds = !flags.c;
      COND_MI: cond_holds = flags.n;
      COND_PL: cond_holds = !flags.n;
      COND_VS: cond_holds = flags.v;
      COND_VC: cond_holds = !flags.v;
      COND_HI: cond_holds = flags.c && !flags.z;
      COND_LS: cond_holds = !flags.c || flags.z;
      COND_GE: cond_holds = (flags.n == flags.v);
      COND_LT: cond_holds = (flags.n != flags.v);
      COND_GT: cond_holds = !flags.z && (flags.n == flags.v);
      COND_LE: cond_holds = flags.z || (flags.n != flags.v);
      COND_AL: cond_holds = 1'b1;
      COND_NV: cond_holds = 1'b0;
      default: cond_holds = 1'b0;
    endcase
  end

  // Sign extend the word offset
  assign offset_ext = {{(WORD_WIDTH-OFFSET_WIDTH){branch_offset[OFFSET_WIDTH-1]}},
                       branch_offset};

  assign target     = next_pc + (offset_ext << 2);  // Offset counts words
  assign taken      = (is_branch || is_link) && cond_holds;
  assign link_taken = taken && is_link;

endmodule

// File: design/ex_stage.sv
// Top level of the execute stage, wiring the ALU path, branch resolver and writeback register
`timescale 1ns/1ns

module ex_stage #(
  parameter int OFFSET_WIDTH = 24
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               in_valid,
  input  arm_isa_pkg::alu_op_t               alu_op,
  input  arm_isa_pkg::addr_mode_t            addr_mode,
  input  logic [arm_isa_pkg::IMM_WIDTH-1:0]  imm12,
  input  ex_types_pkg::word_t                rm_value,
  input  ex_types_pkg::word_t                rn_value,
  input  logic                               store_cc,
  input  logic                               is_branch,
  input  logic                               is_link,
  input  arm_isa_pkg::cond_t                 cond,
  input  logic [OFFSET_WIDTH-1:0]            branch_offset,
  input  ex_types_pkg::word_t                next_pc,
  output logic                               out_valid,
  output ex_types_pkg::word_t                result,
  output ex_types_pkg::flags_t               flags,
  output logic                               branch_taken,
  output ex_types_pkg::word_t                branch_target,
  output logic                               link_write
);

  import ex_types_pkg::*;

  word_t  alu_result;
  flags_t alu_flags;
  logic   taken;
  logic   link_taken;
  word_t  target;

  alu_datapath u_alu_datapath (
    .rm_value   (rm_value),
    .rn_value   (rn_value),
    .imm12      (imm12),
    .addr_mode  (addr_mode),
    .alu_op     (alu_op),
    .carry_in   (flags.c),  // Stored carry
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  branch_resolver #(
    .OFFSET_WIDTH (OFFSET_WIDTH)
  ) u_branch_resolver (
    .cond          (cond),
    .is_branch     (is_branch),
    .is_link       (is_link),
    .branch_offset (branch_offset),
    .next_pc       (next_pc),
    .flags         (flags),
    .taken         (taken),
    .link_taken    (link_taken),
    .target        (target)
  );

  ex_writeback u_ex_writeback (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .store_cc      (store_cc),
    .alu_result    (alu_result),
    .alu_flags     (alu_flags),
    .taken         (taken),
    .link_taken    (link_taken),
    .target        (target),
    .next_pc       (next_pc),
    .flags         (flags),
    .out_valid     (out_valid),
    .result        (result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .link_write    (link_write)
  );

endmodule

// File: design/ex_types_pkg.sv
// Datapath word and status flag types shared by the execute stage RTL and its testbench
package ex_types_pkg;

  localparam int WORD_WIDTH = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // Status flags, N in the top bit
  typedef struct packed {
    logic n;  // Negative
    logic z;  // Zero
    logic c;  // Carry, or borrow after a subtraction
    logic v;  // Signed overflow
  } flags_t;

endpackage

// File: design/ex_writeback.sv
// Flag register and output register of the execute stage, one cycle behind the inputs
`timescale 1ns/1ns

module ex_writeback (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic                   store_cc,
  input  ex_types_pkg::word_t    alu_result,
  input  ex_types_pkg::flags_t   alu_flags,
  input  logic                   taken,
  input  logic                   link_taken,
  input  ex_types_pkg::word_t    target,
  input  ex_types_pkg::word_t    next_pc,
  output ex_types_pkg::flags_t   flags,
  output logic                   out_valid,
  output ex_types_pkg::word_t    result,
  output logic                   branch_taken,
  output ex_types_pkg::word_t    branch_target,
  output logic                   link_write
);

  // PSR, read by the ALU carry and the condition table
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (in_valid && store_cc) begin
      flags <= alu_flags;
    end
  end

  // Control outputs follow in_valid every cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid    <= 1'b0;
      branch_taken <= 1'b0;
      link_write   <= 1'b0;
    end else begin
      out_valid    <= in_valid;
      branch_taken <= in_valid && taken;
      link_write   <= in_valid && link_taken;
    end
  end

  // Payload holds across idle cycles
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      result        <= '0;
      branch_target <= '0;
    end else if (in_valid) begin
      result        <= link_taken ? next_pc : alu_result;  // Return address on BL
      branch_target <= target;
    end
  end

endmodule

// File: ex_stage.f
design/arm_isa_pkg.sv
design/ex_types_pkg.sv
design/alu_datapath.sv
design/branch_resolver.sv
design/ex_writeback.sv
design/ex_stage.sv
sim/ex_stage_props.sv
sim/ex_stage_tb.sv

// File: sim/ex_stage_props.sv
// Output timing properties of the execute stage, attached to the top level by bind
`timescale 1ns/1ns

module ex_stage_props (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic out_valid,
  input logic branch_taken,
  input logic link_write
);

  valid_delay: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(in_valid))
    else $error("out_valid does not follow in_valid by one cycle");

  taken_valid: assert property (@(posedge clk) disable iff (reset) branch_taken |-> out_valid)
    else $error("branch_taken high without out_valid");

  link_taken: assert property (@(posedge clk) disable iff (reset) link_write |-> branch_taken)
    else $error("link_write high without branch_taken");

  // Outputs cleared once reset has been seen at an edge
  reset_clear: assert property (@(posedge clk)
    $past(reset) |-> !out_valid && !branch_taken && !link_write)
    else $error("Control outputs not low during reset");

endmodule

bind ex_stage ex_stage_props u_ex_stage_props (.*);

// File: sim/ex_stage_tb.sv
// Testbench for the execute stage, applies a stimulus table one row per cycle and checks outputs
`timescale 1ns/1ns

module ex_stage_tb;

  import arm_isa_pkg::*;
  import ex_types_pkg::*;

  localparam int    OFFSET_WIDTH = 24;
  localparam int    RESET_CYCLES = 4;
  localparam word_t FILL_RM      = 32'h0000_0b0b;  // MOV operand on branch rows

  typedef struct packed {
    logic                    valid;
    alu_op_t                 alu_op;
    addr_mode_t              addr_mode;
    logic [IMM_WIDTH-1:0]    imm12;
    word_t                   rm_value;
    word_t                   rn_value;
    logic                    store_cc;
    logic                    is_branch;
    logic                    is_link;
    cond_t                   cond;
    logic [OFFSET_WIDTH-1:0] offset;
    word_t                   next_pc;
    word_t                   exp_result;
    flags_t                  exp_flags;  // Flag register after the row
    logic                    exp_taken;
    word_t                   exp_target;
    logic                    exp_link;
  } row_t;

  logic                    clk;
  logic                    reset;
  logic                    in_valid;
  alu_op_t                 alu_op;
  addr_mode_t              addr_mode;
  logic [IMM_WIDTH-1:0]    imm12;
  word_t                   rm_value;
  word_t                   rn_value;
  logic                    store_cc;
  logic                    is_branch;
  logic                    is_link;
  cond_t                   cond;
  logic [OFFSET_WIDTH-1:0] branch_offset;
  word_t                   next_pc;
  logic                    out_valid;
  word_t                   result;
  flags_t                  flags;
  logic                    branch_taken;
  word_t                   branch_target;
  logic                    link_write;

  row_t        rows[$];
  flags_t      psr_model;  // Expected PSR after the last pushed row
  int          row_index;
  int          cycle_count = 0;
  int          max_cycles  = 1000;
  int unsigned seed_value;

  ex_stage #(.OFFSET_WIDTH(OFFSET_WIDTH)) u_ex_stage (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > max_cycles) begin
      abort_run($sformatf("Timeout, table not finished after %0d cycles", cycle_count));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s in row %0d: got 0x%h, expected 0x%h",
                          name, row_index, actual, expected));
    end
  endtask

  task automatic check_flags(input string name, input flags_t actual, input flags_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s in row %0d: got 0x%h, expected 0x%h",
                          name, row_index, actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s in row %0d: got 0x%h, expected 0x%h",
                          name, row_index, actual, expected));
    end
  endtask

  task automatic alu_row(input alu_op_t op, input addr_mode_t mode,
                         input logic [IMM_WIDTH-1:0] imm, input word_t rm, input word_t rn,
                         input logic store, input word_t exp_result, input flags_t new_flags);
    row_t r;
    r            = '0;
    r.valid      = 1'b1;
    r.alu_op     = op;
    r.addr_mode  = mode;
    r.imm12      = imm;
    r.rm_value   = rm;
    r.rn_value   = rn;
    r.store_cc   = store;
    r.exp_result = exp_result;
    if (store) begin
      psr_model = new_flags;
    end
    r.exp_flags = psr_model;
    rows.push_back(r);
  endtask

  task automatic branch_row(input cond_t c, input logic link,
                            input logic [OFFSET_WIDTH-1:0] offset, input word_t pc,
                            input logic exp_taken);
    row_t r;
    int   offset_words;
    offset_words = int'($signed(offset));
    r            = '0;
    r.valid      = 1'b1;
    r.alu_op     = ALU_MOV;
    r.addr_mode  = AM_REG;
    r.rm_value   = FILL_RM;
    r.is_branch  = !link;
    r.is_link    = link;
    r.cond       = c;
    r.offset     = offset;
    r.next_pc    = pc;
    r.exp_taken  = exp_taken;
    r.exp_link   = link && exp_taken;
    r.exp_result = (link && exp_taken) ? pc : FILL_RM;  // Return address on a taken BL
    r.exp_target = pc + word_t'(offset_words * 4);
    r.exp_flags  = psr_model;
    rows.push_back(r);
  endtask

  // All 16 conditions against the current PSR with odd codes as BL
  task automatic cond_sweep(input logic [15:0] holds, input word_t base_pc);
    for (int c = 0; c < 16; c++) begin
      branch_row(cond_t'(c), c[0], OFFSET_WIDTH'(c - 8), base_pc + 32'(c * 8), holds[c]);
    end
  endtask

  // Random operands with store and branch requests that in_valid low must mask
  task automatic idle_row();
    row_t r;
    r            = '0;
    r.alu_op     = ALU_ADD;
    r.rm_value   = $urandom;
    r.rn_value   = $urandom;
    r.imm12      = IMM_WIDTH'($urandom);
    r.next_pc    = $urandom;
    r.store_cc   = 1'b1;
    r.is_branch  = 1'b1;
    r.cond       = COND_AL;
    r.exp_result = rows[$].exp_result;  // Result register holds
    r.exp_target = rows[$].exp_target;  // Target register holds
    r.exp_flags  = psr_model;
    rows.push_back(r);
  endtask

  task automatic build_table();
    alu_row(ALU_ADD, AM_REG, '0, 32'h1, 32'h2, 1'b1, 32'h3, 4'h0);
    alu_row(ALU_ADD, AM_REG, '0, 32'h1, 32'hffff_ffff, 1'b1, 32'h0, 4'h6);  // Z and C
    alu_row(ALU_ADC, AM_REG, '0, 32'h5, 32'h6, 1'b0, 32'hc, 4'h0);
    alu_row(ALU_SUB, AM_REG, '0, 32'h3, 32'h5, 1'b1, 32'h2, 4'h0);
    alu_row(ALU_SUB, AM_REG, '0, 32'h5, 32'h3, 1'b1, 32'hffff_fffe, 4'ha);  // Borrow
    alu_row(ALU_SBC, AM_REG, '0, 32'h1, 32'ha, 1'b0, 32'h8, 4'h0);
    alu_row(ALU_RSB, AM_REG, '0, 32'ha, 32'h4, 1'b0, 32'h6, 4'h0);
    alu_row(ALU_RSC, AM_REG, '0, 32'ha, 32'h4, 1'b0, 32'h5, 4'h0);
    alu_row(ALU_AND, AM_REG, '0, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'hf000_f000, 4'h0);
    alu_row(ALU_EOR, AM_REG, '0, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'h0ff0_0ff0, 4'h0);
    alu_row(ALU_ORR, AM_REG, '0, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'hfff0_fff0, 4'h0);
    alu_row(ALU_BIC, AM_REG, '0, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'h0f00_0f00, 4'h0);
    alu_row(ALU_MOVA, AM_REG, '0, 32'h0, 32'h1234_5678, 1'b0, 32'h1234_5678, 4'h0);
    alu_row(ALU_MOV, AM_REG, '0, 32'hcafe_f00d, 32'h0, 1'b0, 32'hcafe_f00d, 4'h0);
    alu_row(ALU_MVN, AM_REG, '0, 32'hff, 32'h0, 1'b0, 32'hffff_ff00, 4'h0);
    alu_row(alu_op_t'(4'b1000), AM_REG, '0, 32'h1, 32'h1, 1'b1, 32'h0, 4'h4);
    alu_row(ALU_ADD, AM_REG, '0, 32'h7fff_ffff, 32'h1, 1'b1, 32'h8000_0000, 4'h9);
    alu_row(ALU_SBC, AM_REG, '0, 32'h1, 32'ha, 1'b0, 32'h9, 4'h0);  // Carry now clear
    alu_row(ALU_ADC, AM_REG, '0, 32'h5, 32'h6, 1'b0, 32'hb, 4'h0);
    alu_row(ALU_SUB, AM_REG, '0, 32'h1, 32'h8000_0000, 1'b1, 32'h7fff_ffff, 4'h1);
    // Second operand forms seen through MOV
    alu_row(ALU_MOV, AM_ROT_IMM, 12'h4ff, 32'h0, 32'h0, 1'b0, 32'hff00_0000, 4'h0);
    alu_row(ALU_MOV, AM_ROT_IMM, 12'h1ab, 32'h0, 32'h0, 1'b0, 32'hc000_002a, 4'h0);
    alu_row(ALU_MOV, AM_IMM12, 12'habc, 32'h0, 32'h0, 1'b0, 32'h0000_0abc, 4'h0);
    alu_row(ALU_MOV, AM_SHIFT_REG, 12'h200, 32'h1234_5678, 32'h0, 1'b0, 32'h2345_6780, 4'h0);
    alu_row(ALU_MOV, AM_SHIFT_REG, 12'h420, 32'h8765_4321, 32'h0, 1'b0, 32'h0087_6543, 4'h0);
    alu_row(ALU_MOV, AM_SHIFT_REG, 12'h440, 32'h8765_4321, 32'h0, 1'b0, 32'hff87_6543, 4'h0);
    alu_row(ALU_MOV, AM_SHIFT_REG, 12'h860, 32'h1234_5678, 32'h0, 1'b0, 32'h5678_1234, 4'h0);
    idle_row();
    // Condition masks per PSR value with bit n set where condition n holds
    alu_row(ALU_ADD, AM_REG, '0, 32'h1, 32'h2, 1'b1, 32'h3, 4'h0);
    cond_sweep(16'h56aa, 32'h0000_1000);
    idle_row();
    alu_row(ALU_ADD, AM_REG, '0, 32'h1, 32'hffff_ffff, 1'b1, 32'h0, 4'h6);
    cond_sweep(16'h66a5, 32'h0000_2000);
    alu_row(ALU_ADD, AM_REG, '0, 32'h7fff_ffff, 32'h1, 1'b1, 32'h8000_0000, 4'h9);
    cond_sweep(16'h565a, 32'h0000_3000);
    alu_row(ALU_SUB, AM_REG, '0, 32'h5, 32'h3, 1'b1, 32'hffff_fffe, 4'ha);
    cond_sweep(16'h6996, 32'h0000_4000);
    branch_row(COND_AL, 1'b0, 24'h80_0000, 32'h0000_8000, 1'b1);  // Most negative offset
    branch_row(COND_AL, 1'b1, 24'h00_0010, 32'h0000_9000, 1'b1);
    idle_row();
    idle_row();
  endtask

  task automatic drive_row(input row_t r);
    in_valid      = r.valid;
    alu_op        = r.alu_op;
    addr_mode     = r.addr_mode;
    imm12         = r.imm12;
    rm_value      = r.rm_value;
    rn_value      = r.rn_value;
    store_cc      = r.store_cc;
    is_branch     = r.is_branch;
    is_link       = r.is_link;
    cond          = r.cond;
    branch_offset = r.offset;
    next_pc       = r.next_pc;
  endtask

  task automatic check_row(input row_t r);
    check_bit("out_valid", out_valid, r.valid);
    check_bit("branch_taken", branch_taken, r.exp_taken);
    check_bit("link_write", link_write, r.exp_link);
    check_flags("flags", flags, r.exp_flags);
    check_word("result", result, r.exp_result);
    check_word("branch_target", branch_target, r.exp_target);
  endtask

  initial begin
    seed_value = $urandom(32'hb346_4a1f);
    reset      = 1'b1;
    drive_row('0);
    psr_model = '0;
    build_table();
    max_cycles = rows.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset     = 1'b0;
    row_index = -1;  // Outputs straight out of reset
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("branch_taken", branch_taken, 1'b0);
    check_bit("link_write", link_write, 1'b0);
    check_flags("flags", flags, '0);
    check_word("result", result, '0);
    check_word("branch_target", branch_target, '0);
    foreach (rows[i]) begin
      drive_row(rows[i]);
      @(posedge clk);
      #1;
      row_index = i;
      check_row(rows[i]);
    end
    drive_row('0);
    $display("Result: PASSED");
    $finish;
  end

endmodule
